// File: verilog/tsc_pkg.sv
package tsc_pkg;

    localparam int word_w      = 16;
    localparam int reg_addr_w  = 2;
    localparam int queue_depth = 4;
    localparam int queue_ptr_w = $clog2(queue_depth);

    // Opcodes.
    localparam logic [3:0] op_bne   = 4'd0;
    localparam logic [3:0] op_beq   = 4'd1;
    localparam logic [3:0] op_bgz   = 4'd2;
    localparam logic [3:0] op_blz   = 4'd3;
    localparam logic [3:0] op_adi   = 4'd4;
    localparam logic [3:0] op_ori   = 4'd5;
    localparam logic [3:0] op_lhi   = 4'd6;
    localparam logic [3:0] op_lwd   = 4'd7;
    localparam logic [3:0] op_swd   = 4'd8;
    localparam logic [3:0] op_jmp   = 4'd9;
    localparam logic [3:0] op_jal   = 4'd10;
    localparam logic [3:0] op_rtype = 4'd15;

    // Function codes of register-format words.
    localparam logic [5:0] fn_add = 6'd0;
    localparam logic [5:0] fn_sub = 6'd1;
    localparam logic [5:0] fn_and = 6'd2;
    localparam logic [5:0] fn_orr = 6'd3;
    localparam logic [5:0] fn_not = 6'd4;
    localparam logic [5:0] fn_tcp = 6'd5;
    localparam logic [5:0] fn_shl = 6'd6;
    localparam logic [5:0] fn_shr = 6'd7;
    localparam logic [5:0] fn_jpr = 6'd25;
    localparam logic [5:0] fn_jrl = 6'd26;
    localparam logic [5:0] fn_wwd = 6'd28;
    localparam logic [5:0] fn_hlt = 6'd29;

    // ALU selections.
    localparam logic [3:0] alu_add = 4'd0;
    localparam logic [3:0] alu_sub = 4'd1;
    localparam logic [3:0] alu_and = 4'd2;
    localparam logic [3:0] alu_orr = 4'd3;
    localparam logic [3:0] alu_not = 4'd4;
    localparam logic [3:0] alu_tcp = 4'd5;
    localparam logic [3:0] alu_shl = 4'd6;
    localparam logic [3:0] alu_shr = 4'd7;
    localparam logic [3:0] alu_lhi = 4'd8;
    localparam logic [3:0] alu_tgt = 4'd9;
    localparam logic [3:0] alu_idn = 4'd10;
    localparam logic [3:0] alu_zro = 4'd11;

    localparam logic [1:0] br_ne = 2'd0;
    localparam logic [1:0] br_eq = 2'd1;
    localparam logic [1:0] br_gz = 2'd2;
    localparam logic [1:0] br_lz = 2'd3;

    localparam logic [1:0] j_jmp = 2'd0;
    localparam logic [1:0] j_jal = 2'd1;
    localparam logic [1:0] j_jpr = 2'd2;
    localparam logic [1:0] j_jrl = 2'd3;

    localparam logic [1:0] dest_rd  = 2'd0;
    localparam logic [1:0] dest_rt  = 2'd1;
    localparam logic [1:0] dest_two = 2'd2;

    // One instruction word, read as R, I or J format by opcode.
    typedef union packed {
        struct packed {
            logic [3:0]            opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [reg_addr_w-1:0] rd;
            logic [5:0]            funct;
        } r;
        struct packed {
            logic [3:0]            opcode;
            logic [reg_addr_w-1:0] rs;
            logic [reg_addr_w-1:0] rt;
            logic [7:0]            imm;
        } i;
        struct packed {
            logic [3:0]  opcode;
            logic [11:0] target;
        } j;
    } tsc_instr_t;

endpackage

// File: verilog/tsc_fetch_if.sv
interface tsc_fetch_if;
    import tsc_pkg::*;

    logic              push;
    tsc_instr_t        instr;
    logic [word_w-1:0] pc;
    // At least two free entries in the queue.
    logic              space;

    modport fetch (
        output push,
        output instr,
        output pc,
        input  space
    );

    modport queue (
        input  push,
        input  instr,
        input  pc,
        output space
    );

endinterface

// File: verilog/tsc_issue_if.sv
interface tsc_issue_if;
    import tsc_pkg::*;

    logic              valid;
    tsc_instr_t        instr;
    logic [word_w-1:0] pc;
    // Removes the head entry.
    logic              pop;

    modport queue (
        output valid,
        output instr,
        output pc,
        input  pop
    );

    modport execute (
        input  valid,
        input  instr,
        input  pc,
        output pop
    );

endinterface

// File: verilog/tsc_fetch.sv
module tsc_fetch (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic [tsc_pkg::word_w-1:0]  imem_addr,
    output logic                        imem_re,
    input  logic [tsc_pkg::word_w-1:0]  imem_data,
    input  logic                        redirect,
    input  logic [tsc_pkg::word_w-1:0]  target,
    tsc_fetch_if.fetch                  fetch_if
);
    import tsc_pkg::*;

    logic              run;
    logic [word_w-1:0] pc;
    logic              in_flight;
    logic [word_w-1:0] req_pc;

    // Requests start one cycle after reset is released.
    assign imem_re   = run & fetch_if.space & ~redirect;
    assign imem_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run       <= 1'b0;
            pc        <= '0;
            in_flight <= 1'b0;
        end else begin
            run <= 1'b1;
            if (redirect) begin
                pc        <= target;
                in_flight <= 1'b0;
            end else begin
                in_flight <= imem_re;
                if (imem_re) begin
                    pc <= pc + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (imem_re) begin
            req_pc <= pc;
        end
    end

    // A word returning under a redirect belongs to the old path.
    assign fetch_if.push  = in_flight & ~redirect;
    assign fetch_if.instr = imem_data;
    assign fetch_if.pc    = req_pc;

    // A flush leaves room to restart at once.
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> fetch_if.space);

endmodule

// File: verilog/tsc_fetch_queue.sv
module tsc_fetch_queue (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        redirect,
    tsc_fetch_if.queue  fetch_if,
    tsc_issue_if.queue  issue_if
);
    import tsc_pkg::*;

    tsc_instr_t             instr_mem [queue_depth];
    logic [word_w-1:0]      pc_mem [queue_depth];
    logic [queue_ptr_w-1:0] wr_ptr;
    logic [queue_ptr_w-1:0] rd_ptr;
    logic [queue_ptr_w:0]   count;
    logic                   do_push;
    logic                   do_pop;

    // Flush wins over a push in the same cycle.
    assign do_push = fetch_if.push & ~redirect;
    assign do_pop  = issue_if.pop & ~redirect;

    always_ff @(posedge clk) begin
        if (!rst_n || redirect) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (queue_ptr_w + 1)'(do_push) - (queue_ptr_w + 1)'(do_pop);
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            instr_mem[wr_ptr] <= fetch_if.instr;
            pc_mem[wr_ptr]    <= fetch_if.pc;
        end
    end

    // Two free slots cover the one request still in flight.
    assign fetch_if.space = count <= (queue_ptr_w + 1)'(queue_depth - 2);
    assign issue_if.valid = count != '0;
    assign issue_if.instr = instr_mem[rd_ptr];
    assign issue_if.pc    = pc_mem[rd_ptr];

    assert property (@(posedge clk) disable iff (!rst_n)
        issue_if.pop |-> issue_if.valid);

    assert property (@(posedge clk) disable iff (!rst_n)
        count <= (queue_ptr_w + 1)'(queue_depth));

endmodule

// File: verilog/tsc_control_unit.sv
module tsc_control_unit (
    input  tsc_pkg::tsc_instr_t instr,
    output logic                alu_src,
    output logic                reg_write,
    output logic                mem_read,
    output logic                mem_to_reg,
    output logic                mem_write,
    output logic                pc_to_reg,
    output logic                wwd,
    output logic                halt_op,
    output logic [1:0]          reg_write_dest,
    output logic [3:0]          alu_func,
    output logic [1:0]          branch_type,
    output logic [1:0]          jump_type,
    output logic                is_jump,
    output logic                is_branch
);
    import tsc_pkg::*;

    logic is_rtype;
    logic is_itype;
    logic is_load;
    logic is_store;
    logic is_jrel;
    logic is_jwrite;
    logic is_wwd;
    logic is_halt;

    always_comb begin
        is_rtype    = 1'b0;
        is_itype    = 1'b0;
        is_load     = 1'b0;
        is_store    = 1'b0;
        is_jrel     = 1'b0;
        is_jwrite   = 1'b0;
        is_wwd      = 1'b0;
        is_halt     = 1'b0;
        is_jump     = 1'b0;
        is_branch   = 1'b0;
        jump_type   = j_jmp;
        branch_type = br_ne;
        alu_func    = alu_zro;
        case (instr.r.opcode)
            op_adi: begin
                is_itype = 1'b1;
                alu_func = alu_add;
            end
            op_ori: begin
                is_itype = 1'b1;
                alu_func = alu_orr;
            end
            op_lhi: begin
                is_itype = 1'b1;
                alu_func = alu_lhi;
            end
            op_lwd: begin
                is_itype = 1'b1;
                is_load  = 1'b1;
                alu_func = alu_add;
            end
            op_swd: begin
                is_itype = 1'b1;
                is_store = 1'b1;
                alu_func = alu_add;
            end
            op_bne, op_beq, op_bgz, op_blz: begin
                is_branch   = 1'b1;
                // Branch opcodes 0 to 3 map onto the condition codes.
                branch_type = instr.r.opcode[1:0];
            end
            op_jmp, op_jal: begin
                is_jump   = 1'b1;
                is_jrel   = 1'b1;
                is_jwrite = instr.r.opcode == op_jal;
                jump_type = (instr.r.opcode == op_jal) ? j_jal : j_jmp;
                alu_func  = alu_tgt;
            end
            op_rtype: begin
                case (instr.r.funct)
                    fn_add: {is_rtype, alu_func} = {1'b1, alu_add};
                    fn_sub: {is_rtype, alu_func} = {1'b1, alu_sub};
                    fn_and: {is_rtype, alu_func} = {1'b1, alu_and};
                    fn_orr: {is_rtype, alu_func} = {1'b1, alu_orr};
                    fn_not: {is_rtype, alu_func} = {1'b1, alu_not};
                    fn_tcp: {is_rtype, alu_func} = {1'b1, alu_tcp};
                    fn_shl: {is_rtype, alu_func} = {1'b1, alu_shl};
                    fn_shr: {is_rtype, alu_func} = {1'b1, alu_shr};
                    fn_jpr: begin
                        is_jump   = 1'b1;
                        jump_type = j_jpr;
                        alu_func  = alu_idn;
                    end
                    fn_jrl: begin
                        is_jump   = 1'b1;
                        is_jwrite = 1'b1;
                        jump_type = j_jrl;
                        alu_func  = alu_idn;
                    end
                    fn_wwd: {is_wwd, alu_func} = {1'b1, alu_idn};
                    fn_hlt: is_halt = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign alu_src        = is_itype | is_jrel;
    // Only known writers; anything unrecognised leaves the registers alone.
    assign reg_write      = is_rtype | (is_itype & ~is_store) | is_jwrite;
    assign mem_read       = is_load;
    assign mem_to_reg     = is_load;
    assign mem_write      = is_store;
    assign pc_to_reg      = is_jwrite;
    assign reg_write_dest = is_itype ? dest_rt : (is_jwrite ? dest_two : dest_rd);
    assign wwd            = is_wwd;
    assign halt_op        = is_halt;

endmodule

// File: verilog/tsc_execute.sv
module tsc_execute (
    input  logic                       clk,
    input  logic                       rst_n,
    tsc_issue_if.execute               issue_if,
    output logic                       redirect,
    output logic [tsc_pkg::word_w-1:0] target,
    output logic                       dmem_re,
    output logic                       dmem_we,
    output logic [tsc_pkg::word_w-1:0] dmem_addr,
    output logic [tsc_pkg::word_w-1:0] dmem_wdata,
    input  logic [tsc_pkg::word_w-1:0] dmem_rdata,
    output logic                       out_valid,
    output logic [tsc_pkg::word_w-1:0] out_data,
    output logic                       halt
);
    import tsc_pkg::*;

    tsc_instr_t            head;
    logic [word_w-1:0]     rf [2**reg_addr_w];
    logic                  alu_src, reg_write, mem_read, mem_to_reg, mem_write;
    logic                  pc_to_reg, wwd, halt_op, is_jump, is_branch;
    logic [1:0]            reg_write_dest, branch_type, jump_type;
    logic [3:0]            alu_func;
    logic                  go, load_wait, cond, taken;
    logic [reg_addr_w-1:0] dest, load_dest;
    logic [word_w-1:0]     rs_val, rt_val, imm_ext, opnd_b, alu_out, pc_inc, wdata;

    assign head = issue_if.instr;

    tsc_control_unit u_control (
        .instr          (head),
        .alu_src        (alu_src),
        .reg_write      (reg_write),
        .mem_read       (mem_read),
        .mem_to_reg     (mem_to_reg),
        .mem_write      (mem_write),
        .pc_to_reg      (pc_to_reg),
        .wwd            (wwd),
        .halt_op        (halt_op),
        .reg_write_dest (reg_write_dest),
        .alu_func       (alu_func),
        .branch_type    (branch_type),
        .jump_type      (jump_type),
        .is_jump        (is_jump),
        .is_branch      (is_branch)
    );

    // Pop and execute in one cycle.
    assign go           = issue_if.valid & ~halt & ~load_wait;
    assign issue_if.pop = go;

    assign rs_val  = rf[head.i.rs];
    assign rt_val  = rf[head.i.rt];
    assign imm_ext = (head.i.opcode == op_ori) ? {8'h00, head.i.imm}
                                               : {{8{head.i.imm[7]}}, head.i.imm};
    assign opnd_b  = alu_src ? imm_ext : rt_val;
    assign pc_inc  = issue_if.pc + 1'b1;

    always_comb begin
        case (alu_func)
            alu_add: alu_out = rs_val + opnd_b;
            alu_sub: alu_out = rs_val - opnd_b;
            alu_and: alu_out = rs_val & opnd_b;
            alu_orr: alu_out = rs_val | opnd_b;
            alu_not: alu_out = ~rs_val;
            alu_tcp: alu_out = ~rs_val + 1'b1;
            alu_shl: alu_out = {rs_val[word_w-2:0], 1'b0};
            alu_shr: alu_out = {rs_val[word_w-1], rs_val[word_w-1:1]};
            alu_lhi: alu_out = {opnd_b[7:0], 8'h00};
            alu_tgt: alu_out = {issue_if.pc[word_w-1:12], head.j.target};
            alu_idn: alu_out = rs_val;
            default: alu_out = '0;
        endcase
    end

    always_comb begin
        case (branch_type)
            br_ne:   cond = rs_val != rt_val;
            br_eq:   cond = rs_val == rt_val;
            br_gz:   cond = $signed(rs_val) > 0;
            default: cond = $signed(rs_val) < 0;
        endcase
    end

    assign taken    = is_branch & cond;
    assign redirect = go & (taken | is_jump);
    // JMP and JAL take the ALU target; JPR and JRL take rs through identity.
    assign target   = is_jump ? alu_out : pc_inc + imm_ext;
    assign wdata    = pc_to_reg ? pc_inc : alu_out;

    always_comb begin
        case (reg_write_dest)
            dest_rt:  dest = head.i.rt;
            dest_two: dest = reg_addr_w'(2);
            default:  dest = head.r.rd;
        endcase
    end

    assign dmem_re    = go & mem_read;
    assign dmem_we    = go & mem_write;
    assign dmem_addr  = alu_out;
    assign dmem_wdata = rt_val;
    assign out_valid  = go & wwd;
    assign out_data   = alu_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                rf[i] <= '0;
            end
            load_wait <= 1'b0;
            halt      <= 1'b0;
        end else begin
            load_wait <= go & mem_read;
            if (load_wait) begin
                rf[load_dest] <= dmem_rdata;
            end else if (go && reg_write && !mem_to_reg) begin
                rf[dest] <= wdata;
            end
            if (go && halt_op) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go && mem_read) begin
            load_dest <= dest;
        end
    end

    // No wrong-path word reaches the head after a redirect.
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect |=> !issue_if.valid);

endmodule

// File: verilog/tsc_core.sv
module tsc_core (
    input  logic                       clk,
    input  logic                       rst_n,
    output logic [tsc_pkg::word_w-1:0] imem_addr,
    output logic                       imem_re,
    input  logic [tsc_pkg::word_w-1:0] imem_data,
    output logic                       dmem_re,
    output logic                       dmem_we,
    output logic [tsc_pkg::word_w-1:0] dmem_addr,
    output logic [tsc_pkg::word_w-1:0] dmem_wdata,
    input  logic [tsc_pkg::word_w-1:0] dmem_rdata,
    output logic                       out_valid,
    output logic [tsc_pkg::word_w-1:0] out_data,
    output logic                       halt
);

    logic                       redirect;
    logic [tsc_pkg::word_w-1:0] target;

    tsc_fetch_if fetch_if ();
    tsc_issue_if issue_if ();

    tsc_fetch u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .imem_addr (imem_addr),
        .imem_re   (imem_re),
        .imem_data (imem_data),
        .redirect  (redirect),
        .target    (target),
        .fetch_if  (fetch_if.fetch)
    );

    // Redirect doubles as the queue flush.
    tsc_fetch_queue u_queue (
        .clk      (clk),
        .rst_n    (rst_n),
        .redirect (redirect),
        .fetch_if (fetch_if.queue),
        .issue_if (issue_if.queue)
    );

    tsc_execute u_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue_if   (issue_if.execute),
        .redirect   (redirect),
        .target     (target),
        .dmem_re    (dmem_re),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .halt       (halt)
    );

endmodule

// File: verif/tsc_isa_model.svh
`ifndef TSC_ISA_MODEL_SVH
`define TSC_ISA_MODEL_SVH

localparam logic [31:0] lfsr_seed = 32'd75578;

logic [31:0] lfsr_state = lfsr_seed;
logic [15:0] model_ram [ram_words];
logic [15:0] exp_out [$];
logic [15:0] exp_st_addr [$];
logic [15:0] exp_st_data [$];
logic        model_halted;

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1.
function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [15:0] rand_bits(int n);
    logic [15:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[14:0], lfsr_step()};
    end
    return r;
endfunction

function automatic logic [15:0] ram_fill(logic [7:0] a);
    return {a ^ 8'h5c, ~a ^ {a[3:0], a[7:4]}};
endfunction

function automatic logic [15:0] enc_r(logic [5:0] fn, logic [1:0] rs, logic [1:0] rt,
                                      logic [1:0] rd);
    return {op_rtype, rs, rt, rd, fn};
endfunction

function automatic logic [15:0] enc_i(logic [3:0] op, logic [1:0] rs, logic [1:0] rt,
                                      logic [7:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic logic [15:0] enc_j(logic [3:0] op, logic [11:0] tgt);
    return {op, tgt};
endfunction

// Forward only, and never past the closing WWD block.
function automatic int fwd_target(int from);
    int skip;
    skip = int'(rand_bits(2));
    return (from + skip > body_len) ? body_len : from + skip;
endfunction

function automatic void gen_program();
    int         n;
    int         kind;
    int         dest;
    int         max_target;
    logic [1:0] x;
    logic [1:0] y;
    logic [7:0] imm;
    for (int i = 0; i < rom_words; i++) begin
        rom[i] = enc_r(fn_hlt, 2'd0, 2'd0, 2'd0);
    end
    n = 0;
    max_target = 0;
    while (n < body_len) begin
        kind = int'(rand_bits(4));
        x    = 2'(rand_bits(2));
        y    = 2'(rand_bits(2));
        imm  = 8'(rand_bits(8));
        dest = 0;
        // No branch may land between the LHI/ORI setup and its jump.
        if (kind == 13 && (max_target > n || n + 3 > body_len)) begin
            kind = 14;
        end
        case (kind)
            0, 1, 2, 3, 4: rom[n] = enc_r(6'(rand_bits(3)), x, y, 2'(rand_bits(2)));
            5, 6, 7:       rom[n] = enc_i(4'(kind - 1), x, y, imm);
            8:             rom[n] = enc_i(op_lwd, x, y, imm);
            9:             rom[n] = enc_i(op_swd, x, y, imm);
            10:            rom[n] = enc_r(fn_wwd, x, 2'd0, 2'd0);
            11: begin
                dest   = fwd_target(n + 1);
                rom[n] = enc_i({2'b00, y}, x, 2'(rand_bits(2)), 8'(dest - n - 1));
            end
            12: begin
                dest   = fwd_target(n + 1);
                rom[n] = enc_j((rand_bits(1) != 0) ? op_jal : op_jmp, 12'(dest));
            end
            13: begin
                dest       = fwd_target(n + 3);
                rom[n]     = enc_i(op_lhi, 2'd0, x, 8'(dest >> 8));
                rom[n + 1] = enc_i(op_ori, x, x, 8'(dest));
                rom[n + 2] = enc_r(y[0] ? fn_jrl : fn_jpr, x, 2'd0, 2'd0);
                n = n + 2;
            end
            default:       rom[n] = enc_i(op_adi, x, y, imm);
        endcase
        if (dest > max_target) begin
            max_target = dest;
        end
        n = n + 1;
    end
    for (int r = 0; r < 4; r++) begin
        rom[body_len + r] = enc_r(fn_wwd, 2'(r), 2'd0, 2'd0);
    end
    rom[body_len + 4] = enc_r(fn_hlt, 2'd0, 2'd0, 2'd0);
endfunction

// Runs the whole program ahead of time and queues the expected events.
function automatic void run_model();
    logic [15:0] r [4];
    logic [15:0] pc;
    logic [15:0] ins;
    logic [15:0] sx;
    logic [15:0] ea;
    logic [15:0] next;
    logic [1:0]  rs;
    logic [1:0]  rt;
    logic [1:0]  rd;
    for (int i = 0; i < 4; i++) begin
        r[i] = '0;
    end
    for (int i = 0; i < ram_words; i++) begin
        model_ram[i] = ram_fill(8'(i));
    end
    pc = '0;
    model_halted = 1'b0;
    for (int step = 0; step < max_steps && !model_halted; step++) begin
        ins  = rom[pc[7:0]];
        rs   = ins[11:10];
        rt   = ins[9:8];
        rd   = ins[7:6];
        sx   = {{8{ins[7]}}, ins[7:0]};
        ea   = r[rs] + sx;
        next = pc + 16'd1;
        case (ins[15:12])
            op_bne: if (r[rs] != r[rt]) next = next + sx;
            op_beq: if (r[rs] == r[rt]) next = next + sx;
            op_bgz: if (!r[rs][15] && r[rs] != 16'd0) next = next + sx;
            op_blz: if (r[rs][15]) next = next + sx;
            op_adi: r[rt] = ea;
            op_ori: r[rt] = r[rs] | {8'h00, ins[7:0]};
            op_lhi: r[rt] = {ins[7:0], 8'h00};
            op_lwd: r[rt] = model_ram[ea[7:0]];
            op_swd: begin
                model_ram[ea[7:0]] = r[rt];
                exp_st_addr.push_back(ea);
                exp_st_data.push_back(r[rt]);
            end
            op_jmp: next = {pc[15:12], ins[11:0]};
            op_jal: begin
                r[2] = pc + 16'd1;
                next = {pc[15:12], ins[11:0]};
            end
            op_rtype: begin
                case (ins[5:0])
                    fn_add: r[rd] = r[rs] + r[rt];
                    fn_sub: r[rd] = r[rs] - r[rt];
                    fn_and: r[rd] = r[rs] & r[rt];
                    fn_orr: r[rd] = r[rs] | r[rt];
                    fn_not: r[rd] = ~r[rs];
                    fn_tcp: r[rd] = 16'd0 - r[rs];
                    fn_shl: r[rd] = {r[rs][14:0], 1'b0};
                    fn_shr: r[rd] = {r[rs][15], r[rs][15:1]};
                    fn_jpr: next = r[rs];
                    fn_jrl: begin
                        next = r[rs];
                        r[2] = pc + 16'd1;
                    end
                    fn_wwd: exp_out.push_back(r[rs]);
                    fn_hlt: model_halted = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
        pc = next;
    end
endfunction

`endif

// File: verif/tsc_core_tb.sv
module tsc_core_tb;
    import tsc_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 16;
    localparam int drive_dly    = 2;
    localparam int rom_words    = 256;
    localparam int ram_words    = 256;
    localparam int body_len     = 120;
    localparam int max_steps    = 1000;
    localparam int halt_timeout = 3000;
    localparam int hold_cycles  = 50;

    logic              clk;
    logic              rst_n;
    logic [word_w-1:0] imem_addr;
    logic              imem_re;
    logic [word_w-1:0] imem_data;
    logic              dmem_re;
    logic              dmem_we;
    logic [word_w-1:0] dmem_addr;
    logic [word_w-1:0] dmem_wdata;
    logic [word_w-1:0] dmem_rdata;
    logic              out_valid;
    logic [word_w-1:0] out_data;
    logic              halt;

    logic [15:0] rom [rom_words];
    logic [15:0] ram [ram_words];
    logic        imem_req;
    logic [7:0]  imem_req_addr;
    logic        load_req;
    logic        store_req;
    logic [7:0]  data_req_addr;
    logic [15:0] store_data;
    int          out_seen;
    int          store_seen;
    int          exp_out_total;
    int          exp_store_total;

    `include "tsc_isa_model.svh"

    tsc_core DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_addr  (imem_addr),
        .imem_re    (imem_re),
        .imem_data  (imem_data),
        .dmem_re    (dmem_re),
        .dmem_we    (dmem_we),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_rdata (dmem_rdata),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .halt       (halt)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic fail_with(input string why);
        $display("error at time %0t: %s", $time, why);
        abort_run();
    endtask

    task automatic check_equal(input logic [15:0] actual, input logic [15:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Requests are sampled mid-cycle and answered after the next rising edge.
    always @(negedge clk) begin
        imem_req      = imem_re;
        imem_req_addr = imem_addr[7:0];
        load_req      = dmem_re;
        store_req     = dmem_we;
        data_req_addr = dmem_addr[7:0];
        store_data    = dmem_wdata;
    end

    always @(posedge clk) begin
        #drive_dly;
        if (imem_req) begin
            imem_data = rom[imem_req_addr];
        end
        if (store_req) begin
            ram[data_req_addr] = store_data;
        end
        if (load_req) begin
            dmem_rdata = ram[data_req_addr];
        end
    end

    // In-order comparison of WWD outputs and stores.
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_out.size() == 0) begin
                fail_with("WWD output seen after the last expected output");
            end else begin
                check_equal(out_data, exp_out.pop_front(), "WWD output value");
                out_seen++;
            end
        end
        if (rst_n && dmem_we) begin
            if (exp_st_addr.size() == 0) begin
                fail_with("store seen after the last expected store");
            end else begin
                check_equal(dmem_addr, exp_st_addr.pop_front(), "store address");
                check_equal(dmem_wdata, exp_st_data.pop_front(), "store data");
                store_seen++;
            end
        end
    end

    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (reset_cycles - 1) begin
            @(negedge clk);
            check_equal(16'(imem_re), 16'd0, "imem_re during reset");
            check_equal(16'(dmem_re), 16'd0, "dmem_re during reset");
            check_equal(16'(dmem_we), 16'd0, "dmem_we during reset");
            check_equal(16'(out_valid), 16'd0, "out_valid during reset");
            check_equal(16'(halt), 16'd0, "halt during reset");
        end
        @(posedge clk);
        #drive_dly;
        rst_n = 1'b1;
    endtask

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (halt !== 1'b1) begin
            if (cycles == halt_timeout) begin
                fail_with("halt did not rise before the timeout");
            end else begin
                @(negedge clk);
                cycles++;
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        imem_data     = '0;
        dmem_rdata    = '0;
        imem_req      = 1'b0;
        load_req      = 1'b0;
        store_req     = 1'b0;
        imem_req_addr = '0;
        data_req_addr = '0;
        store_data    = '0;
        out_seen      = 0;
        store_seen    = 0;
        gen_program();
        run_model();
        if (!model_halted) begin
            fail_with("reference model never reached HLT");
        end
        exp_out_total   = exp_out.size();
        exp_store_total = exp_st_addr.size();
        for (int i = 0; i < ram_words; i++) begin
            ram[i] = ram_fill(8'(i));
        end
        reset_dut();
        wait_for_halt();
        // Halt holds and the core stays quiet.
        repeat (hold_cycles) begin
            @(negedge clk);
            check_equal(16'(halt), 16'd1, "halt after HLT");
            check_equal(16'(out_valid), 16'd0, "out_valid after halt");
            check_equal(16'(dmem_we), 16'd0, "dmem_we after halt");
        end
        check_equal(16'(out_seen), 16'(exp_out_total), "WWD output count");
        check_equal(16'(store_seen), 16'(exp_store_total), "store count");
        $display("checked %0d WWD outputs and %0d stores", out_seen, store_seen);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// File: build.f
+incdir+verif
verilog/tsc_pkg.sv
verilog/tsc_fetch_if.sv
verilog/tsc_issue_if.sv
verilog/tsc_fetch.sv
verilog/tsc_fetch_queue.sv
verilog/tsc_control_unit.sv
verilog/tsc_execute.sv
verilog/tsc_core.sv
verif/tsc_core_tb.sv

// File: Bender.yml
package:
  name: tsc_core

sources:
  - verilog/tsc_pkg.sv
  - verilog/tsc_fetch_if.sv
  - verilog/tsc_issue_if.sv
  - verilog/tsc_fetch.sv
  - verilog/tsc_fetch_queue.sv
  - verilog/tsc_control_unit.sv
  - verilog/tsc_execute.sv
  - verilog/tsc_core.sv
  - target: test
    include_dirs:
      - verif
    files:
      - verif/tsc_core_tb.sv
